// File: Bender.yml
package:
  name: matmul4

sources:
  - matmul4_pkg.sv
  - matmul4_bus_pkg.sv
  - mm_single_port_ram.sv
  - mm_matrix_banks.sv
  - mm_dot_product.sv
  - mm_sequencer.sv
  - mm_wb_slave.sv
  - matmul4_top.sv
  - target: test
    files:
      - matmul4_checker.sv
      - tb_matmul4_top.sv

// File: matmul4.f
matmul4_pkg.sv
matmul4_bus_pkg.sv
mm_single_port_ram.sv
mm_matrix_banks.sv
mm_dot_product.sv
mm_sequencer.sv
mm_wb_slave.sv
matmul4_top.sv
matmul4_checker.sv
tb_matmul4_top.sv

// File: matmul4_bus_pkg.sv
// bus package: Wishbone request and response structs, address map, region enum
`default_nettype none

package matmul4_bus_pkg;

  // word address width of the slave
  localparam int unsigned wb_adr_w = 6;

  // host side of a classic cycle
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [wb_adr_w-1:0]  adr;
    matmul4_pkg::elem_t   dat;
  } wb_req_t;

  // slave side
  typedef struct packed {
    logic               ack;
    matmul4_pkg::elem_t dat;
  } wb_rsp_t;

  // decoded target of an access
  typedef enum logic [2:0] {
    region_a,
    region_b,
    region_c,
    region_ctrl,
    region_status,
    region_none
  } region_e;

  // matrix windows, 16 words each
  localparam logic [wb_adr_w-1:0] adr_a_base = 6'h00;
  localparam logic [wb_adr_w-1:0] adr_b_base = 6'h10;
  localparam logic [wb_adr_w-1:0] adr_c_base = 6'h20;

  // single registers
  localparam logic [wb_adr_w-1:0] adr_ctrl = 6'h30;
  localparam logic [wb_adr_w-1:0] adr_status = 6'h31;

  // bit positions inside the register words
  localparam int unsigned ctrl_start_bit = 0;
  localparam int unsigned status_busy_bit = 0;
  localparam int unsigned status_done_bit = 1;

endpackage

`default_nettype wire

// File: matmul4_checker.sv
// concurrent assertions on the Wishbone handshake, reset state and status bits of matmul4_top
`timescale 1ns/1ps
`default_nettype none

module matmul4_checker (
  input logic                     clk,
  input logic                     reset,
  input matmul4_bus_pkg::wb_req_t wb_req,
  input matmul4_bus_pkg::wb_rsp_t wb_rsp,
  input logic                     busy,
  input logic                     done_flag
);

  // number of failed assertions
  int assert_failures = 0;

  // ack answers a cycle that was open on the previous edge
  ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
      wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
      $error("ack raised without an open bus cycle");
      assert_failures++;
    end

  // single-cycle ack per transfer
  ack_single: assert property (@(posedge clk) disable iff (reset)
      wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      $error("ack held for two cycles");
      assert_failures++;
    end

  // quiet bus and idle sequencer right after reset
  reset_quiet: assert property (@(posedge clk)
      $fell(reset) |-> (!wb_rsp.ack && !busy))
    else begin
      $error("ack or busy active in the first cycle after reset");
      assert_failures++;
    end

  // status bits are exclusive
  busy_done_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(busy && done_flag))
    else begin
      $error("busy and done set together");
      assert_failures++;
    end

endmodule

`default_nettype wire

// File: matmul4_pkg.sv
// datapath package: element and index types, memory port struct, sequencer states, size constants
`default_nettype none

package matmul4_pkg;

  // element width follows the 18-bit datapath
  localparam int unsigned elem_w = 18;

  // square matrices only
  localparam int unsigned mat_dim = 4;
  localparam int unsigned mat_entries = 16;

  // flat index width, row-major
  localparam int unsigned idx_w = 4;

  typedef logic [elem_w-1:0] elem_t;

  // row is idx[3:2], column is idx[1:0]
  typedef logic [idx_w-1:0] idx_t;

  // one access to a single-port RAM
  typedef struct packed {
    logic  en;
    logic  we;
    idx_t  addr;
    elem_t wdata;
  } mem_port_t;

  // controller states
  typedef enum logic [2:0] {
    seq_idle,
    seq_fetch,
    seq_compute,
    seq_drain,
    seq_done
  } seq_state_e;

endpackage

`default_nettype wire

// File: matmul4_top.sv
// matmul4 top level: bus slave, matrix RAMs and sequencer
`timescale 1ns/1ps
`default_nettype none

module matmul4_top (
  input  logic                      clk,
  input  logic                      reset,
  input  matmul4_bus_pkg::wb_req_t  wb_req,
  output matmul4_bus_pkg::wb_rsp_t  wb_rsp
);

  // bus side RAM ports
  matmul4_pkg::mem_port_t bus_a;
  matmul4_pkg::mem_port_t bus_b;
  matmul4_pkg::mem_port_t bus_c;

  // sequencer side RAM ports
  matmul4_pkg::mem_port_t seq_ab;
  matmul4_pkg::mem_port_t seq_c;

  matmul4_pkg::elem_t     q_a;
  matmul4_pkg::elem_t     q_b;
  matmul4_pkg::elem_t     q_c;

  // control handshake
  logic                   busy;
  logic                   done;
  logic                   start;

  mm_wb_slave u_slave (
    .clk        (clk),
    .reset      (reset),
    .req        (wb_req),
    .rsp        (wb_rsp),
    .bus_a      (bus_a),
    .bus_b      (bus_b),
    .bus_c      (bus_c),
    .q_a        (q_a),
    .q_b        (q_b),
    .q_c        (q_c),
    .busy       (busy),
    .done_pulse (done),
    .start      (start)
  );

  mm_matrix_banks u_banks (
    .clk    (clk),
    .bus_a  (bus_a),
    .bus_b  (bus_b),
    .bus_c  (bus_c),
    .seq_ab (seq_ab),
    .seq_c  (seq_c),
    .busy   (busy),
    .q_a    (q_a),
    .q_b    (q_b),
    .q_c    (q_c)
  );

  mm_sequencer u_seq (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .q_a    (q_a),
    .q_b    (q_b),
    .seq_ab (seq_ab),
    .seq_c  (seq_c),
    .busy   (busy),
    .done   (done)
  );

endmodule

`default_nettype wire

// File: mm_dot_product.sv
// two-stage pipelined four-term multiply-accumulate with result index
`timescale 1ns/1ps
`default_nettype none

module mm_dot_product (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           issue_valid,
  input  matmul4_pkg::idx_t                              issue_idx,
  input  matmul4_pkg::elem_t [matmul4_pkg::mat_dim-1:0]  row,
  input  matmul4_pkg::elem_t [matmul4_pkg::mat_dim-1:0]  col,
  output logic                                           res_valid,
  output matmul4_pkg::idx_t                              res_idx,
  output matmul4_pkg::elem_t                             res_sum
);

  matmul4_pkg::elem_t [matmul4_pkg::mat_dim-1:0] prod_d;
  matmul4_pkg::elem_t [matmul4_pkg::mat_dim-1:0] prod_q;
  matmul4_pkg::elem_t                            sum_d;
  logic                                          valid_s1;
  matmul4_pkg::idx_t                             idx_s1;

  // products truncated to the element width by assignment
  always_comb begin
    for (int k = 0; k < matmul4_pkg::mat_dim; k++) begin
      prod_d[k] = row[k] * col[k];
    end
  end

  // sum wraps modulo 2^18
  always_comb begin
    sum_d = '0;
    for (int k = 0; k < matmul4_pkg::mat_dim; k++) begin
      sum_d = sum_d + prod_q[k];
    end
  end

  // valid bits per stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_s1  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      valid_s1  <= issue_valid;
      res_valid <= valid_s1;
    end
  end

  // payload, index travels with data
  always_ff @(posedge clk) begin
    prod_q  <= prod_d;
    idx_s1  <= issue_idx;
    res_sum <= sum_d;
    res_idx <= idx_s1;
  end

endmodule

`default_nettype wire

// File: mm_matrix_banks.sv
// matrix storage: RAMs for A, B and C with bus or sequencer ownership
`timescale 1ns/1ps
`default_nettype none

module mm_matrix_banks (
  input  logic                   clk,
  input  matmul4_pkg::mem_port_t bus_a,
  input  matmul4_pkg::mem_port_t bus_b,
  input  matmul4_pkg::mem_port_t bus_c,
  input  matmul4_pkg::mem_port_t seq_ab,
  input  matmul4_pkg::mem_port_t seq_c,
  input  logic                   busy,
  output matmul4_pkg::elem_t     q_a,
  output matmul4_pkg::elem_t     q_b,
  output matmul4_pkg::elem_t     q_c
);

  matmul4_pkg::mem_port_t port_a;
  matmul4_pkg::mem_port_t port_b;
  matmul4_pkg::mem_port_t port_c;

  // sequencer owns all three RAMs while busy
  // A and B share one address stream
  always_comb begin
    if (busy) begin
      port_a = seq_ab;
      port_b = seq_ab;
      port_c = seq_c;
    end else begin
      port_a = bus_a;
      port_b = bus_b;
      port_c = bus_c;
    end
  end

  mm_single_port_ram u_ram_a (
    .clk  (clk),
    .port (port_a),
    .q    (q_a)
  );

  mm_single_port_ram u_ram_b (
    .clk  (clk),
    .port (port_b),
    .q    (q_b)
  );

  // result matrix
  mm_single_port_ram u_ram_c (
    .clk  (clk),
    .port (port_c),
    .q    (q_c)
  );

endmodule

`default_nettype wire

// File: mm_sequencer.sv
// controller FSM: fetch A and B, issue 16 dot products, store C
`timescale 1ns/1ps
`default_nettype none

module mm_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  matmul4_pkg::elem_t     q_a,
  input  matmul4_pkg::elem_t     q_b,
  output matmul4_pkg::mem_port_t seq_ab,
  output matmul4_pkg::mem_port_t seq_c,
  output logic                   busy,
  output logic                   done
);

  matmul4_pkg::seq_state_e state;

  // one extra bit marks the end of the fetch stream
  logic [matmul4_pkg::idx_w:0] step;
  matmul4_pkg::idx_t           issue_idx;
  logic                        fetch_en;
  logic                        issue_valid;

  // read return tracking, one cycle RAM latency
  logic                        rd_valid;
  matmul4_pkg::idx_t           rd_idx;

  // local copies of A and B, row-major
  matmul4_pkg::elem_t a_reg [matmul4_pkg::mat_entries];
  matmul4_pkg::elem_t b_reg [matmul4_pkg::mat_entries];

  matmul4_pkg::elem_t [matmul4_pkg::mat_dim-1:0] row;
  matmul4_pkg::elem_t [matmul4_pkg::mat_dim-1:0] col;

  logic                res_valid;
  matmul4_pkg::idx_t   res_idx;
  matmul4_pkg::elem_t  res_sum;

  assign issue_idx   = step[matmul4_pkg::idx_w-1:0];
  assign fetch_en    = (state == matmul4_pkg::seq_fetch) && !step[matmul4_pkg::idx_w];
  assign issue_valid = (state == matmul4_pkg::seq_compute);

  assign busy = (state == matmul4_pkg::seq_fetch) || (state == matmul4_pkg::seq_compute) ||
                (state == matmul4_pkg::seq_drain);
  assign done = (state == matmul4_pkg::seq_done);

  // A and B read together, never written here
  always_comb begin
    seq_ab.en    = fetch_en;
    seq_ab.we    = 1'b0;
    seq_ab.addr  = issue_idx;
    seq_ab.wdata = '0;
  end

  // every returned sum goes straight into C
  always_comb begin
    seq_c.en    = res_valid;
    seq_c.we    = res_valid;
    seq_c.addr  = res_idx;
    seq_c.wdata = res_sum;
  end

  // row i of A, column j of B
  always_comb begin
    for (int k = 0; k < matmul4_pkg::mat_dim; k++) begin
      row[k] = a_reg[{issue_idx[3:2], 2'(k)}];
      col[k] = b_reg[{2'(k), issue_idx[1:0]}];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= matmul4_pkg::seq_idle;
      step     <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= fetch_en;
      case (state)
        matmul4_pkg::seq_idle: begin
          step <= '0;
          if (start) begin
            state <= matmul4_pkg::seq_fetch;
          end
        end
        matmul4_pkg::seq_fetch: begin
          if (fetch_en) begin
            step <= step + 1'b1;
          end
          // last word captured, start issuing
          if (rd_valid && (rd_idx == '1)) begin
            step  <= '0;
            state <= matmul4_pkg::seq_compute;
          end
        end
        matmul4_pkg::seq_compute: begin
          step <= step + 1'b1;
          if (issue_idx == '1) begin
            state <= matmul4_pkg::seq_drain;
          end
        end
        matmul4_pkg::seq_drain: begin
          // wait for the final result to land in C
          if (res_valid && (res_idx == '1)) begin
            state <= matmul4_pkg::seq_done;
          end
        end
        default: begin
          state <= matmul4_pkg::seq_idle;
        end
      endcase
    end
  end

  // fetch data path
  always_ff @(posedge clk) begin
    rd_idx <= issue_idx;
    if (rd_valid) begin
      a_reg[rd_idx] <= q_a;
      b_reg[rd_idx] <= q_b;
    end
  end

  mm_dot_product u_dot (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_idx   (issue_idx),
    .row         (row),
    .col         (col),
    .res_valid   (res_valid),
    .res_idx     (res_idx),
    .res_sum     (res_sum)
  );

endmodule

`default_nettype wire

// File: mm_single_port_ram.sv
// 16-entry single-port RAM, synchronous read-before-write with clock enable
`timescale 1ns/1ps
`default_nettype none

module mm_single_port_ram (
  input  logic                   clk,
  input  matmul4_pkg::mem_port_t port,
  output matmul4_pkg::elem_t     q
);

  // one word per matrix element
  matmul4_pkg::elem_t mem [matmul4_pkg::mat_entries];

  // en gates both read and write
  // a write also returns the old word
  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.we) begin
        mem[port.addr] <= port.wdata;
      end
      q <= mem[port.addr];
    end
  end

endmodule

`default_nettype wire

// File: mm_wb_slave.sv
// Wishbone classic slave: address decode, control and status registers, ack generation
`timescale 1ns/1ps
`default_nettype none

module mm_wb_slave (
  input  logic                      clk,
  input  logic                      reset,
  input  matmul4_bus_pkg::wb_req_t  req,
  output matmul4_bus_pkg::wb_rsp_t  rsp,
  output matmul4_pkg::mem_port_t    bus_a,
  output matmul4_pkg::mem_port_t    bus_b,
  output matmul4_pkg::mem_port_t    bus_c,
  input  matmul4_pkg::elem_t        q_a,
  input  matmul4_pkg::elem_t        q_b,
  input  matmul4_pkg::elem_t        q_c,
  input  logic                      busy,
  input  logic                      done_pulse,
  output logic                      start
);

  localparam int unsigned hi = matmul4_bus_pkg::wb_adr_w - 1;
  localparam int unsigned lo = matmul4_pkg::idx_w;

  matmul4_bus_pkg::region_e region;
  logic                     ack_q;
  matmul4_pkg::elem_t       rdata_q;
  logic                     mem_phase;
  logic                     done_flag;
  logic                     access;
  logic                     mem_region;
  logic                     mem_go;
  matmul4_pkg::elem_t       status_word;
  matmul4_pkg::elem_t       mem_q;

  // upper bits pick the window
  always_comb begin
    if (req.adr[hi:lo] == matmul4_bus_pkg::adr_a_base[hi:lo]) begin
      region = matmul4_bus_pkg::region_a;
    end else if (req.adr[hi:lo] == matmul4_bus_pkg::adr_b_base[hi:lo]) begin
      region = matmul4_bus_pkg::region_b;
    end else if (req.adr[hi:lo] == matmul4_bus_pkg::adr_c_base[hi:lo]) begin
      region = matmul4_bus_pkg::region_c;
    end else if (req.adr == matmul4_bus_pkg::adr_ctrl) begin
      region = matmul4_bus_pkg::region_ctrl;
    end else if (req.adr == matmul4_bus_pkg::adr_status) begin
      region = matmul4_bus_pkg::region_status;
    end else begin
      region = matmul4_bus_pkg::region_none;
    end
  end

  // new request, not yet answered
  assign access     = req.cyc && req.stb && !ack_q;
  assign mem_region = (region == matmul4_bus_pkg::region_a) ||
                      (region == matmul4_bus_pkg::region_b) ||
                      (region == matmul4_bus_pkg::region_c);
  // memory held off while the sequencer owns the RAMs
  assign mem_go     = access && mem_region && !busy && !mem_phase;

  // write enables only for A and B
  always_comb begin
    bus_a.en    = mem_go && (region == matmul4_bus_pkg::region_a);
    bus_a.we    = req.we;
    bus_a.addr  = req.adr[lo-1:0];
    bus_a.wdata = req.dat;
    bus_b.en    = mem_go && (region == matmul4_bus_pkg::region_b);
    bus_b.we    = req.we;
    bus_b.addr  = req.adr[lo-1:0];
    bus_b.wdata = req.dat;
    // C is read-only from the bus
    bus_c.en    = mem_go && (region == matmul4_bus_pkg::region_c);
    bus_c.we    = 1'b0;
    bus_c.addr  = req.adr[lo-1:0];
    bus_c.wdata = req.dat;
  end

  always_comb begin
    status_word = '0;
    status_word[matmul4_bus_pkg::status_busy_bit] = busy;
    status_word[matmul4_bus_pkg::status_done_bit] = done_flag;
  end

  always_comb begin
    case (region)
      matmul4_bus_pkg::region_a: mem_q = q_a;
      matmul4_bus_pkg::region_b: mem_q = q_b;
      default:                   mem_q = q_c;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_q     <= 1'b0;
      mem_phase <= 1'b0;
      start     <= 1'b0;
      done_flag <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      start <= 1'b0;
      if (done_pulse) begin
        done_flag <= 1'b1;
      end
      if (mem_phase) begin
        // RAM word is valid now
        ack_q     <= 1'b1;
        mem_phase <= 1'b0;
      end else if (access) begin
        if (mem_region) begin
          mem_phase <= mem_go;
        end else begin
          ack_q <= 1'b1;
          // start only from idle, also clears done
          if ((region == matmul4_bus_pkg::region_ctrl) && req.we && !busy &&
              req.dat[matmul4_bus_pkg::ctrl_start_bit]) begin
            start     <= 1'b1;
            done_flag <= 1'b0;
          end
        end
      end
    end
  end

  // read data register
  always_ff @(posedge clk) begin
    if (mem_phase) begin
      rdata_q <= mem_q;
    end else if (access && !mem_region) begin
      rdata_q <= (region == matmul4_bus_pkg::region_status) ? status_word : '0;
    end
  end

  always_comb begin
    rsp.ack = ack_q;
    rsp.dat = rdata_q;
  end

endmodule

`default_nettype wire

// File: tb_matmul4_top.sv
// testbench for matmul4_top: clock, reset, bus tasks, random matrices, reference model, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_matmul4_top;

  // longest test loads both matrices in roughly 3.8 us
  localparam int num_tests = 8;
  localparam int test_budget_ns = 5000;

  logic                     clk;
  logic                     reset;
  matmul4_bus_pkg::wb_req_t wb_req;
  matmul4_bus_pkg::wb_rsp_t wb_rsp;

  integer seed;
  int     checks;
  int     errors;
  int     test_num;
  int     test_errors;

  // host-side copies and expected product
  matmul4_pkg::elem_t a_mem [matmul4_pkg::mat_entries];
  matmul4_pkg::elem_t b_mem [matmul4_pkg::mat_entries];
  matmul4_pkg::elem_t c_exp [matmul4_pkg::mat_entries];

  matmul4_top DUT (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  bind matmul4_top matmul4_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .busy      (busy),
    .done_flag (u_slave.done_flag)
  );

  always #10 clk = ~clk;

  function automatic matmul4_pkg::elem_t rand_elem();
    logic [31:0] r;
    r = $random(seed);
    return r[matmul4_pkg::elem_w-1:0];
  endfunction

  // base plus element offset inside a 16-word window
  function automatic logic [5:0] mat_adr(input logic [5:0] base, input int k);
    return base | 6'(k);
  endfunction

  // C = A x B with each product and each sum wrapped at 18 bits
  task automatic compute_model();
    logic [2*matmul4_pkg::elem_w-1:0] full;
    matmul4_pkg::elem_t               acc;
    for (int i = 0; i < matmul4_pkg::mat_dim; i++) begin
      for (int j = 0; j < matmul4_pkg::mat_dim; j++) begin
        acc = '0;
        for (int k = 0; k < matmul4_pkg::mat_dim; k++) begin
          full = a_mem[i*4+k] * b_mem[k*4+j];
          acc  = acc + full[matmul4_pkg::elem_w-1:0];
        end
        c_exp[i*4+j] = acc;
      end
    end
  endtask

  // classic cycle held until ack and sampled on the falling edge
  task automatic bus_write(input logic [5:0] adr, input matmul4_pkg::elem_t dat);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    wb_req = '0;
  endtask

  task automatic bus_read(input logic [5:0] adr, output matmul4_bus_pkg::wb_rsp_t rsp);
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    rsp    = wb_rsp;
    wb_req = '0;
  endtask

  task automatic compare_elem(input matmul4_pkg::elem_t got, input matmul4_pkg::elem_t exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at time %0t: %s read 0x%05h, expected 0x%05h", $time, what, got, exp);
    end
  endtask

  task automatic compare_status(input matmul4_bus_pkg::wb_rsp_t rsp, input logic exp_busy,
                                input logic exp_done, input string what);
    logic got_busy;
    logic got_done;
    got_busy = rsp.dat[matmul4_bus_pkg::status_busy_bit];
    got_done = rsp.dat[matmul4_bus_pkg::status_done_bit];
    checks++;
    if (got_busy !== exp_busy || got_done !== exp_done) begin
      errors++;
      $display("** Error at time %0t: %s busy=%b done=%b, expected busy=%b done=%b",
               $time, what, got_busy, got_done, exp_busy, exp_done);
    end
  endtask

  task automatic fill_random();
    for (int k = 0; k < matmul4_pkg::mat_entries; k++) begin
      a_mem[k] = rand_elem();
      b_mem[k] = rand_elem();
    end
  endtask

  task automatic load_matrices();
    for (int k = 0; k < matmul4_pkg::mat_entries; k++) begin
      bus_write(mat_adr(matmul4_bus_pkg::adr_a_base, k), a_mem[k]);
      bus_write(mat_adr(matmul4_bus_pkg::adr_b_base, k), b_mem[k]);
    end
  endtask

  task automatic start_run();
    matmul4_pkg::elem_t val;
    val = '0;
    val[matmul4_bus_pkg::ctrl_start_bit] = 1'b1;
    bus_write(matmul4_bus_pkg::adr_ctrl, val);
  endtask

  // poll status until done and return the last status word
  task automatic wait_done(output matmul4_bus_pkg::wb_rsp_t rsp);
    bus_read(matmul4_bus_pkg::adr_status, rsp);
    while (!rsp.dat[matmul4_bus_pkg::status_done_bit]) begin
      bus_read(matmul4_bus_pkg::adr_status, rsp);
    end
  endtask

  task automatic check_c();
    matmul4_bus_pkg::wb_rsp_t rsp;
    for (int k = 0; k < matmul4_pkg::mat_entries; k++) begin
      bus_read(mat_adr(matmul4_bus_pkg::adr_c_base, k), rsp);
      compare_elem(rsp.dat, c_exp[k], $sformatf("C[%0d]", k));
    end
  endtask

  task automatic run_product();
    matmul4_bus_pkg::wb_rsp_t rsp;
    compute_model();
    start_run();
    wait_done(rsp);
    check_c();
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: fail (%0d errors)", test_num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    matmul4_bus_pkg::wb_rsp_t rsp;
    matmul4_pkg::elem_t       new_val;
    clk         = 1'b0;
    reset       = 1'b1;
    wb_req      = '0;
    seed        = 32'h1254;
    checks      = 0;
    errors      = 0;
    test_num    = 0;
    test_errors = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // memory windows and read latency
    fill_random();
    load_matrices();
    for (int k = 0; k < matmul4_pkg::mat_entries; k++) begin
      bus_read(mat_adr(matmul4_bus_pkg::adr_a_base, k), rsp);
      compare_elem(rsp.dat, a_mem[k], $sformatf("A[%0d]", k));
      bus_read(mat_adr(matmul4_bus_pkg::adr_b_base, k), rsp);
      compare_elem(rsp.dat, b_mem[k], $sformatf("B[%0d]", k));
    end
    end_test("load and read back A and B");

    run_product();
    end_test("random product 1");
    fill_random();
    load_matrices();
    run_product();
    end_test("random product 2");
    fill_random();
    load_matrices();
    run_product();
    end_test("random product 3");

    // all-ones A against B columns that alternate small and near-maximum values
    for (int k = 0; k < matmul4_pkg::mat_entries; k++) begin
      a_mem[k] = 18'h3ffff;
      b_mem[k] = k[0] ? 18'h3ffff - 18'(k) : 18'(k) + 18'd1;
    end
    load_matrices();
    run_product();
    end_test("18-bit truncation");

    // status sequence with a second start dropped while busy
    start_run();
    bus_read(matmul4_bus_pkg::adr_status, rsp);
    compare_status(rsp, 1'b1, 1'b0, "status after start");
    start_run();
    wait_done(rsp);
    compare_status(rsp, 1'b0, 1'b1, "status at completion");
    bus_read(matmul4_bus_pkg::adr_status, rsp);
    compare_status(rsp, 1'b0, 1'b1, "status after dropped start");
    check_c();
    start_run();
    bus_read(matmul4_bus_pkg::adr_status, rsp);
    compare_status(rsp, 1'b1, 1'b0, "status after second start");
    wait_done(rsp);
    compare_status(rsp, 1'b0, 1'b1, "status after second run");
    end_test("status and start handling");

    // A write during busy waits for done
    start_run();
    new_val = rand_elem();
    bus_write(mat_adr(matmul4_bus_pkg::adr_a_base, 5), new_val);
    bus_read(matmul4_bus_pkg::adr_status, rsp);
    compare_status(rsp, 1'b0, 1'b1, "status after held write");
    check_c();
    bus_read(mat_adr(matmul4_bus_pkg::adr_a_base, 5), rsp);
    compare_elem(rsp.dat, new_val, "A[5] after held write");
    a_mem[5] = new_val;
    end_test("write during busy");

    // C, status and unmapped writes are dropped
    bus_write(mat_adr(matmul4_bus_pkg::adr_c_base, 3), ~c_exp[3]);
    bus_read(mat_adr(matmul4_bus_pkg::adr_c_base, 3), rsp);
    compare_elem(rsp.dat, c_exp[3], "C[3] after bus write");
    bus_write(matmul4_bus_pkg::adr_status, '0);
    bus_read(matmul4_bus_pkg::adr_status, rsp);
    compare_status(rsp, 1'b0, 1'b1, "status after status write");
    bus_write(6'h3a, rand_elem());
    bus_read(6'h3a, rsp);
    compare_elem(rsp.dat, '0, "unmapped 0x3a");
    bus_read(matmul4_bus_pkg::adr_ctrl, rsp);
    compare_elem(rsp.dat, '0, "ctrl read");
    bus_read(mat_adr(matmul4_bus_pkg::adr_a_base, 10), rsp);
    compare_elem(rsp.dat, a_mem[10], "A[10] after unmapped write");
    bus_read(mat_adr(matmul4_bus_pkg::adr_b_base, 10), rsp);
    compare_elem(rsp.dat, b_mem[10], "B[10] after unmapped write");
    end_test("ignored writes and unmapped reads");

    $display("tests=%0d checks=%0d errors=%0d assertion failures=%0d",
             test_num, checks, errors, DUT.u_checker.assert_failures);
    if (errors == 0 && DUT.u_checker.assert_failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog budget is the per-test budget times the number of tests
  initial begin
    #(num_tests * test_budget_ns);
    $display("watchdog expired after %0d ns, the DUT stopped answering",
             num_tests * test_budget_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
